//--- design/nice_pkg.sv
/*
  Shared definitions for the NICE co-processor core
  - Data and address widths, row-buffer index and depth
  - Custom-3 opcode and the func3/func7 pairs of lbuf, sbuf, rowsum
  - ICB word step and size code
  - Decoded instruction and controller state enums
  - CPU request, ICB command and ICB response structs
*/
`default_nettype none

package nice_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  localparam int word_w        = 32;
  localparam int row_buf_depth = 4;

  typedef logic [word_w-1:0] word_t;
  typedef logic [word_w-1:0] addr_t;
  // Index into the row buffer
  typedef logic [1:0]        row_idx_t;

  //////////////////////////////////////////////////
  // Instruction encoding
  //////////////////////////////////////////////////
  // Custom-3, R type only
  localparam logic [6:0] opcode_custom3 = 7'b1111011;

  localparam logic [2:0] lbuf_func3   = 3'b010;
  localparam logic [6:0] lbuf_func7   = 7'b0000001;
  localparam logic [2:0] sbuf_func3   = 3'b010;
  localparam logic [6:0] sbuf_func7   = 7'b0000010;
  localparam logic [2:0] rowsum_func3 = 3'b110;
  localparam logic [6:0] rowsum_func7 = 7'b0000110;

  // Byte increment between consecutive words
  localparam addr_t      word_step     = 32'd4;
  // ICB size code of a full 32-bit word
  localparam logic [1:0] icb_size_word = 2'b10;

  //////////////////////////////////////////////////
  // Enums and channel structs
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {op_none, op_lbuf, op_sbuf, op_rowsum} nice_op_e;

  typedef enum logic [1:0] {st_idle, st_lbuf, st_sbuf, st_rowsum} ctrl_state_e;

  // CPU request payload
  typedef struct packed {
    word_t inst;
    addr_t rs1;
  } nice_req_t;

  // ICB command payload
  typedef struct packed {
    addr_t      addr;
    logic       read;
    word_t      wdata;
    logic [1:0] size;
  } icb_cmd_t;

  // ICB response payload
  typedef struct packed {
    word_t rdata;
    logic  err;
  } icb_rsp_t;

endpackage

`default_nettype wire

//--- design/nice_ctrl.sv
/*
  NICE controller
  - Custom-3 decoder for lbuf, sbuf and rowsum
  - Controller FSM
  - ICB command and response counters
  - CPU and ICB handshakes, datapath strobes and indices
*/
`default_nettype none

module nice_ctrl #(
  parameter int row_words = 3
) (
  input  wire                  nice_clk,
  input  wire                  nice_rst_n,
  input  wire                  nice_req_valid,
  input  nice_pkg::nice_req_t  nice_req,
  input  wire                  nice_rsp_ready,
  input  wire                  nice_icb_cmd_ready,
  input  wire                  nice_icb_rsp_valid,
  input  wire                  icb_err,
  input  wire                  rsum_ready,
  output logic                 nice_req_ready,
  output logic                 nice_rsp_valid,
  output logic                 nice_rsp_err,
  output logic                 nice_icb_cmd_valid,
  output logic                 icb_read,
  output logic                 addr_start,
  output logic                 addr_step,
  output nice_pkg::row_idx_t   cmd_idx,
  output nice_pkg::row_idx_t   rsp_idx,
  output logic                 lbuf_wr,
  output logic                 rsum_rcv,
  output logic                 rsp_done_rowsum,
  output logic                 rowsum_sel,
  output logic                 nice_active,
  output logic                 nice_mem_holdup
);

  // Counts run 0..row_words, so one bit wider than the index
  typedef logic [2:0] cnt_t;

  localparam cnt_t row_cnt  = cnt_t'(row_words);
  localparam cnt_t last_cnt = cnt_t'(row_words - 1);

  nice_pkg::nice_op_e    op;
  nice_pkg::ctrl_state_e state;
  cnt_t                  cmd_cnt;
  cnt_t                  rsp_cnt;
  logic                  idle;
  logic                  mem_op;
  logic                  req_hs;
  logic                  cmd_hs;
  logic                  rsp_hs;
  logic                  last_rsp;
  logic                  buf_state;
  logic                  row_done;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  always_comb
  begin
    op = nice_pkg::op_none;
    if (nice_req.inst[6:0] == nice_pkg::opcode_custom3)
    begin
      // func3 in [14:12], func7 in [31:25]
      if (nice_req.inst[14:12] == nice_pkg::lbuf_func3 &&
          nice_req.inst[31:25] == nice_pkg::lbuf_func7)
        op = nice_pkg::op_lbuf;
      else if (nice_req.inst[14:12] == nice_pkg::sbuf_func3 &&
               nice_req.inst[31:25] == nice_pkg::sbuf_func7)
        op = nice_pkg::op_sbuf;
      else if (nice_req.inst[14:12] == nice_pkg::rowsum_func3 &&
               nice_req.inst[31:25] == nice_pkg::rowsum_func7)
        op = nice_pkg::op_rowsum;
    end
  end

  assign mem_op    = (op != nice_pkg::op_none);
  assign idle      = (state == nice_pkg::st_idle);
  assign buf_state = (state == nice_pkg::st_lbuf) | (state == nice_pkg::st_sbuf);

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////
  // A memory request needs the ICB command port, since its first command goes out at once
  assign nice_req_ready = idle & ((nice_req_valid & ~mem_op) | nice_icb_cmd_ready);
  assign req_hs         = nice_req_valid & nice_req_ready;

  // First command in idle with the request, the rest from the busy states
  assign nice_icb_cmd_valid = (idle & nice_req_valid & mem_op) |
                              (~idle & (cmd_cnt < row_cnt));
  assign cmd_hs             = nice_icb_cmd_valid & nice_icb_cmd_ready;

  // ICB response ready is tied high at the top
  assign rsp_hs   = nice_icb_rsp_valid & ~idle;
  assign last_rsp = rsp_hs & (rsp_cnt == last_cnt);

  // lbuf and sbuf answer with the last ICB response, rowsum once the sum is final
  assign nice_rsp_valid  = (buf_state & last_rsp) |
                           ((state == nice_pkg::st_rowsum) & rsum_ready);
  assign rsp_done_rowsum = (state == nice_pkg::st_rowsum) & rsum_ready & nice_rsp_ready;
  assign nice_rsp_err    = nice_icb_rsp_valid & icb_err;

  assign row_done = (buf_state & last_rsp) | rsp_done_rowsum;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      state <= nice_pkg::st_idle;
    else
    begin
      case (state)
        nice_pkg::st_idle:
        begin
          if (req_hs && op == nice_pkg::op_lbuf)
            state <= nice_pkg::st_lbuf;
          else if (req_hs && op == nice_pkg::op_sbuf)
            state <= nice_pkg::st_sbuf;
          else if (req_hs && op == nice_pkg::op_rowsum)
            state <= nice_pkg::st_rowsum;
        end
        default:
        begin
          if (row_done)
            state <= nice_pkg::st_idle;
        end
      endcase
    end
  end

  // Command and response counters, both cleared at the end of the row
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      cmd_cnt <= '0;
      rsp_cnt <= '0;
    end
    else if (row_done)
    begin
      cmd_cnt <= '0;
      rsp_cnt <= '0;
    end
    else
    begin
      if (cmd_hs)
        cmd_cnt <= cmd_cnt + cnt_t'(1);
      if (rsp_hs)
        rsp_cnt <= rsp_cnt + cnt_t'(1);
    end
  end

  //////////////////////////////////////////////////
  // Datapath steering
  //////////////////////////////////////////////////
  // In idle the command kind comes from the decoder, later from the state
  assign icb_read   = idle ? (op != nice_pkg::op_sbuf) : (state != nice_pkg::st_sbuf);
  assign addr_start = idle;
  assign addr_step  = cmd_hs;
  assign cmd_idx    = cmd_cnt[1:0];
  assign rsp_idx    = rsp_cnt[1:0];
  assign lbuf_wr    = (state == nice_pkg::st_lbuf) & rsp_hs;
  assign rsum_rcv   = (state == nice_pkg::st_rowsum) & rsp_hs;
  assign rowsum_sel = (state == nice_pkg::st_rowsum);

  assign nice_active     = idle ? nice_req_valid : 1'b1;
  assign nice_mem_holdup = ~idle;

endmodule

`default_nettype wire

//--- design/nice_addr_gen.sv
/*
  ICB address generator
  - Passes rs1 through for the first command of a row
  - Accumulator stepping one word per accepted command
*/
`default_nettype none

module nice_addr_gen (
  input  wire              nice_clk,
  input  wire              nice_rst_n,
  input  nice_pkg::addr_t  rs1,
  input  wire              addr_start,
  input  wire              addr_step,
  output nice_pkg::addr_t  cmd_addr
);

  nice_pkg::addr_t addr_acc;
  nice_pkg::addr_t addr_next;

  // Base address only while the request is still in idle
  assign cmd_addr = addr_start ? rs1 : addr_acc;

  // Next word after the one being sent
  assign addr_next = cmd_addr + nice_pkg::word_step;

  //////////////////////////////////////////////////
  // Accumulator
  //////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      addr_acc <= '0;
    else if (addr_step)
      addr_acc <= addr_next;
  end

endmodule

`default_nettype wire

//--- design/nice_row_buf.sv
/*
  Row buffer of row_buf_depth words
  - lbuf write port from the ICB response
  - rowsum read-add-write port
  - Combinational read port for sbuf write data
*/
`default_nettype none

module nice_row_buf (
  input  wire                 nice_clk,
  input  wire                 nice_rst_n,
  input  wire                 lbuf_wr,
  input  nice_pkg::row_idx_t  wr_idx,
  input  nice_pkg::word_t     wr_data,
  input  wire                 add_en,
  input  nice_pkg::row_idx_t  add_idx,
  input  nice_pkg::word_t     add_data,
  input  nice_pkg::row_idx_t  rd_idx,
  output nice_pkg::word_t     rd_data
);

  nice_pkg::word_t row_mem [nice_pkg::row_buf_depth];

  //////////////////////////////////////////////////
  // Write and accumulate
  //////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      for (int i = 0; i < nice_pkg::row_buf_depth; i++)
        row_mem[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < nice_pkg::row_buf_depth; i++)
      begin
        // Load from memory overrides an add to the same entry
        if (lbuf_wr && wr_idx == nice_pkg::row_idx_t'(i))
          row_mem[i] <= wr_data;
        else if (add_en && add_idx == nice_pkg::row_idx_t'(i))
          row_mem[i] <= row_mem[i] + add_data;
      end
    end
  end

  // sbuf reads the entry of the command being sent
  assign rd_data = row_mem[rd_idx];

endmodule

`default_nettype wire

//--- design/nice_rowsum_acc.sv
/*
  Row-sum pipeline for rowsum
  - Receive register for each response word and its index
  - Running sum of the row
  - Add port to the row buffer and the sum-final flag
*/
`default_nettype none

module nice_rowsum_acc #(
  parameter int row_words = 3
) (
  input  wire                 nice_clk,
  input  wire                 nice_rst_n,
  input  wire                 rsum_rcv,
  input  nice_pkg::row_idx_t  rcv_idx,
  input  nice_pkg::word_t     rdata,
  input  wire                 rsp_done,
  output logic                add_en,
  output nice_pkg::row_idx_t  add_idx,
  output nice_pkg::word_t     add_data,
  output nice_pkg::word_t     row_sum,
  output logic                rsum_ready
);

  localparam nice_pkg::row_idx_t last_idx = nice_pkg::row_idx_t'(row_words - 1);

  logic               rcv_valid;
  nice_pkg::row_idx_t rcv_idx_q;
  nice_pkg::word_t    rcv_data;
  nice_pkg::word_t    acc;

  //////////////////////////////////////////////////
  // Receive stage
  //////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      rcv_valid <= 1'b0;
      rcv_idx_q <= '0;
    end
    else
    begin
      rcv_valid <= rsum_rcv;
      if (rsum_rcv)
        rcv_idx_q <= rcv_idx;
    end
  end

  always_ff @(posedge nice_clk)
  begin
    if (rsum_rcv)
      rcv_data <= rdata;
  end

  //////////////////////////////////////////////////
  // Accumulate stage
  //////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      acc        <= '0;
      rsum_ready <= 1'b0;
    end
    else
    begin
      // Word 0 starts a new row
      if (rcv_valid)
        acc <= (rcv_idx_q == '0) ? rcv_data : acc + rcv_data;
      if (rsp_done)
        rsum_ready <= 1'b0;
      else if (rcv_valid && rcv_idx_q == last_idx)
        rsum_ready <= 1'b1;
    end
  end

  // Same word goes into the matching row-buffer entry
  assign add_en   = rcv_valid;
  assign add_idx  = rcv_idx_q;
  assign add_data = rcv_data;
  assign row_sum  = acc;

endmodule

`default_nettype wire

//--- design/nice_core.sv
/*
  NICE co-processor top level
  - Controller, address generator, row buffer, row-sum pipeline
  - CPU request and response channels
  - ICB command and response channels
*/
`default_nettype none

module nice_core #(
  parameter int row_words = 3
) (
  input  wire                  nice_clk,
  input  wire                  nice_rst_n,
  input  wire                  nice_req_valid,
  input  nice_pkg::nice_req_t  nice_req,
  input  wire                  nice_rsp_ready,
  input  wire                  nice_icb_cmd_ready,
  input  wire                  nice_icb_rsp_valid,
  input  nice_pkg::icb_rsp_t   nice_icb_rsp,
  output logic                 nice_req_ready,
  output logic                 nice_rsp_valid,
  output nice_pkg::word_t      nice_rsp_rdat,
  output logic                 nice_rsp_err,
  output logic                 nice_icb_cmd_valid,
  output nice_pkg::icb_cmd_t   nice_icb_cmd,
  output logic                 nice_icb_rsp_ready,
  output logic                 nice_active,
  output logic                 nice_mem_holdup
);

  logic               icb_read;
  logic               addr_start;
  logic               addr_step;
  logic               lbuf_wr;
  logic               rsum_rcv;
  logic               rsp_done_rowsum;
  logic               rowsum_sel;
  logic               rsum_ready;
  logic               add_en;
  nice_pkg::row_idx_t cmd_idx;
  nice_pkg::row_idx_t rsp_idx;
  nice_pkg::row_idx_t add_idx;
  nice_pkg::addr_t    cmd_addr;
  nice_pkg::word_t    sbuf_wdata;
  nice_pkg::word_t    add_data;
  nice_pkg::word_t    row_sum;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////
  nice_ctrl #(
    .row_words (row_words)
  ) u_ctrl (
    .nice_clk           (nice_clk),
    .nice_rst_n         (nice_rst_n),
    .nice_req_valid     (nice_req_valid),
    .nice_req           (nice_req),
    .nice_rsp_ready     (nice_rsp_ready),
    .nice_icb_cmd_ready (nice_icb_cmd_ready),
    .nice_icb_rsp_valid (nice_icb_rsp_valid),
    .icb_err            (nice_icb_rsp.err),
    .rsum_ready         (rsum_ready),
    .nice_req_ready     (nice_req_ready),
    .nice_rsp_valid     (nice_rsp_valid),
    .nice_rsp_err       (nice_rsp_err),
    .nice_icb_cmd_valid (nice_icb_cmd_valid),
    .icb_read           (icb_read),
    .addr_start         (addr_start),
    .addr_step          (addr_step),
    .cmd_idx            (cmd_idx),
    .rsp_idx            (rsp_idx),
    .lbuf_wr            (lbuf_wr),
    .rsum_rcv           (rsum_rcv),
    .rsp_done_rowsum    (rsp_done_rowsum),
    .rowsum_sel         (rowsum_sel),
    .nice_active        (nice_active),
    .nice_mem_holdup    (nice_mem_holdup)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////
  nice_addr_gen u_addr_gen (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .rs1        (nice_req.rs1),
    .addr_start (addr_start),
    .addr_step  (addr_step),
    .cmd_addr   (cmd_addr)
  );

  nice_row_buf u_row_buf (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .lbuf_wr    (lbuf_wr),
    .wr_idx     (rsp_idx),
    .wr_data    (nice_icb_rsp.rdata),
    .add_en     (add_en),
    .add_idx    (add_idx),
    .add_data   (add_data),
    .rd_idx     (cmd_idx),
    .rd_data    (sbuf_wdata)
  );

  nice_rowsum_acc #(
    .row_words (row_words)
  ) u_rowsum_acc (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .rsum_rcv   (rsum_rcv),
    .rcv_idx    (rsp_idx),
    .rdata      (nice_icb_rsp.rdata),
    .rsp_done   (rsp_done_rowsum),
    .add_en     (add_en),
    .add_idx    (add_idx),
    .add_data   (add_data),
    .row_sum    (row_sum),
    .rsum_ready (rsum_ready)
  );

  // ICB command assembled from control, address and row buffer
  assign nice_icb_cmd.addr  = cmd_addr;
  assign nice_icb_cmd.read  = icb_read;
  assign nice_icb_cmd.wdata = sbuf_wdata;
  assign nice_icb_cmd.size  = nice_pkg::icb_size_word;

  // Responses are never back-pressured
  assign nice_icb_rsp_ready = 1'b1;

  // Only rowsum returns data in rd
  assign nice_rsp_rdat = rowsum_sel ? row_sum : '0;

endmodule

`default_nettype wire

//--- test/nice_mem_model.sv
/*
  ICB memory responder for the NICE core testbench
  - Word array filled from the byte address at reset
  - Random command stalls from a fixed seed
  - In-order response one cycle after each accepted command
  - Error flag on one armed address and a log of every command
*/
`default_nettype none

module nice_mem_model (
  input  wire                 nice_clk,
  input  wire                 nice_rst_n,
  input  wire                 cmd_valid,
  input  nice_pkg::icb_cmd_t  cmd,
  output logic                cmd_ready,
  output logic                rsp_valid,
  output nice_pkg::icb_rsp_t  rsp,
  input  wire                 err_arm,
  input  nice_pkg::addr_t     err_addr
);
  timeunit 1ns;
  timeprecision 1ps;

  // 256 words at byte address bits [9:2]
  nice_pkg::word_t mem [256];
  // One log entry per accepted command
  nice_pkg::addr_t cmd_log [64];
  logic            read_log [64];
  logic [1:0]      size_log [64];
  int              cmd_count;
  integer          seed = 32'h64cd;
  logic            cmd_hs;

  // Every word lies above 32'hf000_0000 so any three of them overflow
  function automatic nice_pkg::word_t fill_word(input nice_pkg::addr_t a);
    return 32'hf000_0000 + a * 32'h0001_0003;
  endfunction

  assign cmd_hs = cmd_valid & cmd_ready;

  //////////////////////////////////////////////////
  // Command accept and response
  //////////////////////////////////////////////////
  always @(posedge nice_clk)
  begin
    if (!nice_rst_n)
    begin
      for (int i = 0; i < 256; i++)
        mem[8'(i)] <= fill_word(nice_pkg::addr_t'(i * 4));
      cmd_ready <= 1'b0;
      rsp_valid <= 1'b0;
      rsp       <= '0;
      cmd_count <= 0;
    end
    else
    begin
      // Ready roughly three cycles in four
      cmd_ready <= ($random(seed) % 4) != 0;
      rsp_valid <= cmd_hs;
      if (cmd_hs)
      begin
        if (cmd_count < 64)
        begin
          cmd_log[6'(cmd_count)]  <= cmd.addr;
          read_log[6'(cmd_count)] <= cmd.read;
          size_log[6'(cmd_count)] <= cmd.size;
        end
        cmd_count <= cmd_count + 1;
        rsp.err   <= err_arm && (cmd.addr == err_addr);
        if (cmd.read)
          rsp.rdata <= mem[cmd.addr[9:2]];
        else
        begin
          // Write returns no data
          rsp.rdata           <= '0;
          mem[cmd.addr[9:2]]  <= cmd.wdata;
        end
      end
      else
        rsp <= '0;
    end
  end

endmodule

`default_nettype wire

//--- test/nice_core_tb.sv
/*
  Testbench for the NICE core with three-word rows
  - Clock, reset and cycle-limit timeout
  - Instruction driver with response wait and hold
  - Typed compare tasks for words, addresses and flags
  - Directed tests for lbuf, sbuf, rowsum, errors and unknown words
*/
`default_nettype none

module nice_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int row_words  = 3;
  localparam int max_cycles = 2000;

  logic                nice_clk = 1'b0;
  logic                nice_rst_n;
  logic                nice_req_valid;
  nice_pkg::nice_req_t nice_req;
  logic                nice_rsp_ready;
  logic                nice_icb_cmd_ready;
  logic                nice_icb_rsp_valid;
  nice_pkg::icb_rsp_t  nice_icb_rsp;
  logic                nice_req_ready;
  logic                nice_rsp_valid;
  nice_pkg::word_t     nice_rsp_rdat;
  logic                nice_rsp_err;
  logic                nice_icb_cmd_valid;
  nice_pkg::icb_cmd_t  nice_icb_cmd;
  logic                nice_icb_rsp_ready;
  logic                nice_active;
  logic                nice_mem_holdup;
  logic                err_arm;
  nice_pkg::addr_t     err_addr;
  int                  errors = 0;
  int                  checks = 0;
  int                  cycles = 0;
  integer              seed = 32'h64cd;

  //////////////////////////////////////////////////
  // DUT and memory
  //////////////////////////////////////////////////
  nice_core #(
    .row_words (row_words)
  ) u_dut (
    .nice_clk           (nice_clk),
    .nice_rst_n         (nice_rst_n),
    .nice_req_valid     (nice_req_valid),
    .nice_req           (nice_req),
    .nice_rsp_ready     (nice_rsp_ready),
    .nice_icb_cmd_ready (nice_icb_cmd_ready),
    .nice_icb_rsp_valid (nice_icb_rsp_valid),
    .nice_icb_rsp       (nice_icb_rsp),
    .nice_req_ready     (nice_req_ready),
    .nice_rsp_valid     (nice_rsp_valid),
    .nice_rsp_rdat      (nice_rsp_rdat),
    .nice_rsp_err       (nice_rsp_err),
    .nice_icb_cmd_valid (nice_icb_cmd_valid),
    .nice_icb_cmd       (nice_icb_cmd),
    .nice_icb_rsp_ready (nice_icb_rsp_ready),
    .nice_active        (nice_active),
    .nice_mem_holdup    (nice_mem_holdup)
  );

  nice_mem_model u_mem (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .cmd_valid  (nice_icb_cmd_valid),
    .cmd        (nice_icb_cmd),
    .cmd_ready  (nice_icb_cmd_ready),
    .rsp_valid  (nice_icb_rsp_valid),
    .rsp        (nice_icb_rsp),
    .err_arm    (err_arm),
    .err_addr   (err_addr)
  );

  // 20 ns period
  always #10 nice_clk = ~nice_clk;

  // Run limit in clock cycles, far above the directed test length
  always @(posedge nice_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles)
    begin
      $display("Timeout: the tests did not finish within %0d clock cycles", max_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_word(input nice_pkg::word_t got, input nice_pkg::word_t exp,
                            input string msg);
    checks++;
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input nice_pkg::addr_t got, input nice_pkg::addr_t exp,
                            input string msg);
    checks++;
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s, got %b, expected %b", $time, msg, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  // R type with rd x10, rs1 x11 and rs2 x12
  function automatic nice_pkg::word_t make_inst(input logic [2:0] func3,
                                                input logic [6:0] func7);
    return {func7, 5'd12, 5'd11, func3, 5'd10, nice_pkg::opcode_custom3};
  endfunction

  function automatic nice_pkg::word_t mem_word(input nice_pkg::addr_t a);
    return u_mem.mem[a[9:2]];
  endfunction

  // Checks the logged addresses, kind and size of the last row of commands
  task automatic verify_cmd_log(input int first, input nice_pkg::addr_t base, input logic rd);
    check_word(nice_pkg::word_t'(u_mem.cmd_count - first), nice_pkg::word_t'(row_words),
               "command count of the row");
    for (int i = 0; i < row_words; i++)
    begin
      check_addr(u_mem.cmd_log[6'(first + i)], base + nice_pkg::addr_t'(4 * i),
                 "command address");
      check_bit(u_mem.read_log[6'(first + i)], rd, "command read flag");
      // ICB size 2 means four bytes
      check_word(nice_pkg::word_t'(u_mem.size_log[6'(first + i)]), 32'd2,
                 "command size code");
    end
  endtask

  // Issues one instruction and waits for its response
  // hold > 0 keeps rsp_ready low that many cycles after rsp_valid
  task automatic run_instr(input nice_pkg::word_t inst, input nice_pkg::addr_t rs1,
                           input int hold, output nice_pkg::word_t rdat,
                           output logic err_seen);
    err_seen = 1'b0;
    @(posedge nice_clk);
    nice_req_valid <= 1'b1;
    nice_req.inst  <= inst;
    nice_req.rs1   <= rs1;
    nice_rsp_ready <= (hold == 0);
    @(negedge nice_clk);
    check_bit(nice_active, 1'b1, "nice_active with a pending request");
    while (!nice_req_ready)
      @(negedge nice_clk);
    @(posedge nice_clk);
    nice_req_valid <= 1'b0;
    @(negedge nice_clk);
    // Error flag can come on any response of the row
    while (!nice_rsp_valid)
    begin
      err_seen = err_seen | nice_rsp_err;
      check_bit(nice_active, 1'b1, "nice_active while busy");
      if (nice_icb_rsp_valid)
        check_bit(nice_icb_rsp_ready, 1'b1, "icb_rsp_ready with a response");
      @(negedge nice_clk);
    end
    err_seen = err_seen | nice_rsp_err;
    rdat = nice_rsp_rdat;
    for (int i = 0; i < hold; i++)
    begin
      @(negedge nice_clk);
      check_bit(nice_rsp_valid, 1'b1, "rsp_valid while rsp_ready low");
      check_word(nice_rsp_rdat, rdat, "rsp_rdat while rsp_ready low");
      check_bit(nice_mem_holdup, 1'b1, "mem_holdup while rsp_ready low");
    end
    if (hold > 0)
    begin
      @(posedge nice_clk);
      nice_rsp_ready <= 1'b1;
      @(negedge nice_clk);
      check_bit(nice_rsp_valid, 1'b1, "rsp_valid at the response handshake");
    end
    @(posedge nice_clk);
    @(negedge nice_clk);
    check_bit(nice_mem_holdup, 1'b0, "mem_holdup after the response");
    check_bit(nice_active, 1'b0, "nice_active after the response");
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  // lbuf from a and sbuf to b
  task automatic copy_row(input nice_pkg::addr_t a, input nice_pkg::addr_t b);
    nice_pkg::word_t src [row_words];
    nice_pkg::word_t rdat;
    logic            err;
    int              first;
    for (int i = 0; i < row_words; i++)
      src[i] = mem_word(a + nice_pkg::addr_t'(4 * i));
    first = u_mem.cmd_count;
    run_instr(make_inst(nice_pkg::lbuf_func3, nice_pkg::lbuf_func7), a, 0, rdat, err);
    check_bit(err, 1'b0, "lbuf error flag");
    check_word(rdat, '0, "lbuf rd data");
    verify_cmd_log(first, a, 1'b1);
    first = u_mem.cmd_count;
    run_instr(make_inst(nice_pkg::sbuf_func3, nice_pkg::sbuf_func7), b, 0, rdat, err);
    check_word(rdat, '0, "sbuf rd data");
    verify_cmd_log(first, b, 1'b0);
    for (int i = 0; i < row_words; i++)
      check_word(mem_word(b + nice_pkg::addr_t'(4 * i)), src[i], "copied memory word");
  endtask

  // rowsum over a row whose sum overflows 32 bits
  task automatic sum_row(input nice_pkg::addr_t c, input int hold);
    nice_pkg::word_t exp;
    nice_pkg::word_t rdat;
    logic            err;
    longint          wide;
    exp  = '0;
    wide = 0;
    for (int i = 0; i < row_words; i++)
    begin
      exp  = exp + mem_word(c + nice_pkg::addr_t'(4 * i));
      wide = wide + longint'(mem_word(c + nice_pkg::addr_t'(4 * i)));
    end
    check_bit(wide > 64'hffff_ffff, 1'b1, "rowsum test row wraps around");
    run_instr(make_inst(nice_pkg::rowsum_func3, nice_pkg::rowsum_func7), c, hold, rdat,
              err);
    check_word(rdat, exp, "rowsum rd data");
  endtask

  // lbuf x, rowsum y, sbuf z gives z[i] = x[i] + y[i]
  task automatic add_rows(input nice_pkg::addr_t x, input nice_pkg::addr_t y,
                          input nice_pkg::addr_t z);
    nice_pkg::word_t exp [row_words];
    nice_pkg::word_t rdat;
    logic            err;
    for (int i = 0; i < row_words; i++)
      exp[i] = mem_word(x + nice_pkg::addr_t'(4 * i)) + mem_word(y + nice_pkg::addr_t'(4 * i));
    run_instr(make_inst(nice_pkg::lbuf_func3, nice_pkg::lbuf_func7), x, 0, rdat, err);
    sum_row(y, 0);
    run_instr(make_inst(nice_pkg::sbuf_func3, nice_pkg::sbuf_func7), z, 0, rdat, err);
    for (int i = 0; i < row_words; i++)
      check_word(mem_word(z + nice_pkg::addr_t'(4 * i)), exp[i], "summed row word");
  endtask

  // Armed error on the second word of an lbuf
  task automatic load_with_error(input nice_pkg::addr_t e);
    nice_pkg::word_t rdat;
    logic            err;
    @(posedge nice_clk);
    err_arm  <= 1'b1;
    err_addr <= e + nice_pkg::word_step;
    run_instr(make_inst(nice_pkg::lbuf_func3, nice_pkg::lbuf_func7), e, 0, rdat, err);
    check_bit(err, 1'b1, "rsp_err on the armed lbuf response");
    @(posedge nice_clk);
    err_arm <= 1'b0;
  endtask

  // Custom-3 word with no matching func3 and func7
  task automatic send_unknown_word();
    int first;
    first = u_mem.cmd_count;
    @(posedge nice_clk);
    nice_req_valid <= 1'b1;
    nice_req.inst  <= make_inst(3'b000, 7'b0000000);
    nice_req.rs1   <= 32'h0000_0020;
    @(negedge nice_clk);
    while (!nice_req_ready)
      @(negedge nice_clk);
    @(posedge nice_clk);
    nice_req_valid <= 1'b0;
    repeat (10)
    begin
      @(negedge nice_clk);
      check_bit(nice_icb_cmd_valid, 1'b0, "no ICB command after unknown word");
      check_bit(nice_rsp_valid, 1'b0, "no response after unknown word");
      check_bit(nice_mem_holdup, 1'b0, "mem_holdup after unknown word");
      check_bit(nice_active, 1'b0, "nice_active after unknown word");
    end
    check_word(nice_pkg::word_t'(u_mem.cmd_count - first), '0, "commands after unknown word");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    nice_rst_n     = 1'b0;
    nice_req_valid = 1'b0;
    nice_req       = '0;
    nice_rsp_ready = 1'b1;
    err_arm        = 1'b0;
    err_addr       = '0;
    repeat (2) @(posedge nice_clk);
    nice_rst_n <= 1'b1;
    copy_row(32'h0000_0100, 32'h0000_0200);
    sum_row(32'h0000_0040, 0);
    add_rows(32'h0000_0300, 32'h0000_0180, 32'h0000_0380);
    sum_row(32'h0000_0280, 2 + ($random(seed) & 7));
    load_with_error(32'h0000_00c0);
    send_unknown_word();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
design/nice_pkg.sv
design/nice_ctrl.sv
design/nice_addr_gen.sv
design/nice_row_buf.sv
design/nice_rowsum_acc.sv
design/nice_core.sv
test/nice_mem_model.sv
test/nice_core_tb.sv

//--- run.sh
#!/bin/sh
# Compile the NICE core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module nice_core_tb \
  -f sources.f \
  -o nice_core_tb

out=$(./obj_dir/nice_core_tb)
echo "$out"

# Pass only if the testbench printed its pass line
if echo "$out" | grep -q "^Simulation completed successfully$"; then
  exit 0
fi
exit 1
